//--- source/scb_types_pkg.sv
// =========================================================================
// Scoreboard widths and sizes
// =========================================================================

package scb_types_pkg;

	// Architectural register count, register 0 reads as zero
	localparam int NREGS = 64;

	// Number of reorder buffer entries, kept a power of two
	localparam int ROB_ENTRIES = 8;

	// Width of one architectural data word
	localparam int DATA_BITS = 64;

	// Index widths follow from the sizes above
	localparam int REG_BITS = $clog2(NREGS);
	localparam int TAG_BITS = $clog2(ROB_ENTRIES);

	// A register number
	typedef logic [REG_BITS-1:0] reg_idx_t;

	// A reorder entry index, also used as the producer tag of a register
	typedef logic [TAG_BITS-1:0] rob_tag_t;

	// A data word as held in the register file
	typedef logic [DATA_BITS-1:0] word_t;

endpackage

//--- source/scb_ctrl_pkg.sv
// =========================================================================
// Reorder control encodings
// =========================================================================

package scb_ctrl_pkg;

	// Life cycle of one reorder entry
	// An entry is issued at dispatch and done once its result arrives
	typedef enum logic [1:0] {
		ROB_EMPTY  = 2'd0,
		ROB_ISSUED = 2'd1,
		ROB_DONE   = 2'd2
	} rob_state_e;

	// At most this many done entries leave the head per cycle
	localparam int COMMIT_LANES = 2;

	// Dispatch only opens when a full pair of entries is free
	// so a two wide group never has to be split
	localparam int DISP_SLOTS = 2;

endpackage

//--- source/reorder_buffer.sv
// =========================================================================
// Two wide reorder buffer
// =========================================================================
`timescale 1ns/10ps

module reorder_buffer
	import scb_types_pkg::*;
	import scb_ctrl_pkg::*;
#(
	parameter int rob_depth = 8,
	parameter int DATA_WIDTH = 64,
	localparam int TAG_W = $clog2(rob_depth)
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  disp_valid0,
	input  logic                  disp_wr0,
	input  reg_idx_t              disp_tgt0,
	input  logic                  disp_valid1,
	input  logic                  disp_wr1,
	input  reg_idx_t              disp_tgt1,
	output logic                  disp_ready,
	output logic [TAG_W-1:0]      disp_tag0,
	output logic [TAG_W-1:0]      disp_tag1,
	input  logic                  done_valid,
	input  logic [TAG_W-1:0]      done_tag,
	input  logic [DATA_WIDTH-1:0] done_value,
	input  logic                  branchmiss,
	output logic                  alloc0_wr,
	output reg_idx_t              alloc0_tgt,
	output logic [TAG_W-1:0]      alloc0_tag,
	output logic                  alloc1_wr,
	output reg_idx_t              alloc1_tgt,
	output logic [TAG_W-1:0]      alloc1_tag,
	output logic                  commit0_wr,
	output reg_idx_t              commit0_tgt,
	output logic [TAG_W-1:0]      commit0_tag,
	output logic [DATA_WIDTH-1:0] commit0_value,
	output logic                  commit1_wr,
	output reg_idx_t              commit1_tgt,
	output logic [TAG_W-1:0]      commit1_tag,
	output logic [DATA_WIDTH-1:0] commit1_value
);

	// Ring pointers and occupancy, count needs one bit more than a tag
	logic [TAG_W-1:0] head;
	logic [TAG_W-1:0] tail;
	logic [TAG_W:0]   count;
	logic [TAG_W:0]   free_slots;
	logic [TAG_W:0]   n_alloc;
	logic [TAG_W:0]   n_commit;

	// Per entry state and payload
	rob_state_e            state [rob_depth];
	logic                  ent_wr [rob_depth];
	reg_idx_t              ent_tgt [rob_depth];
	logic [DATA_WIDTH-1:0] ent_value [rob_depth];

	logic                    acc0;
	logic                    acc1;
	logic [TAG_W-1:0]        lane_idx [COMMIT_LANES];
	logic [COMMIT_LANES-1:0] lane_fire;

	// =====================================================================
	// Dispatch side
	// =====================================================================

	assign free_slots = (TAG_W+1)'(rob_depth) - count;

	// A flush cycle never takes new work
	assign disp_ready = !branchmiss && (free_slots >= (TAG_W+1)'(DISP_SLOTS));
	assign disp_tag0 = tail;
	assign disp_tag1 = tail + 1'b1;

	assign acc0 = disp_valid0 && disp_ready;
	assign acc1 = disp_valid1 && disp_ready;

	// Writes to register 0 are dropped here so no later block sees them
	assign alloc0_wr = acc0 && disp_wr0 && (disp_tgt0 != '0);
	assign alloc0_tgt = disp_tgt0;
	assign alloc0_tag = disp_tag0;
	assign alloc1_wr = acc1 && disp_wr1 && (disp_tgt1 != '0);
	assign alloc1_tgt = disp_tgt1;
	assign alloc1_tag = disp_tag1;

	assign n_alloc = (TAG_W+1)'(acc0) + (TAG_W+1)'(acc1);

	// =====================================================================
	// Commit side
	// =====================================================================

	// Each lane looks one entry further from the head
	// A lane retires only when every lane before it retires too
	always_comb begin
		lane_idx[0] = head;
		lane_fire[0] = (state[head] == ROB_DONE);
		n_commit = (TAG_W+1)'(lane_fire[0]);
		for (int i = 1; i < COMMIT_LANES; i++) begin
			lane_idx[i] = head + TAG_W'(i);
			lane_fire[i] = lane_fire[i-1] && (state[lane_idx[i]] == ROB_DONE);
			n_commit = n_commit + (TAG_W+1)'(lane_fire[i]);
		end
	end

	assign commit0_wr = lane_fire[0] && ent_wr[lane_idx[0]];
	assign commit0_tgt = ent_tgt[lane_idx[0]];
	assign commit0_tag = lane_idx[0];
	assign commit0_value = ent_value[lane_idx[0]];
	assign commit1_wr = lane_fire[1] && ent_wr[lane_idx[1]];
	assign commit1_tgt = ent_tgt[lane_idx[1]];
	assign commit1_tag = lane_idx[1];
	assign commit1_value = ent_value[lane_idx[1]];

	// =====================================================================
	// State update
	// =====================================================================

	always_ff @(posedge clk) begin
		if (rst || branchmiss) begin
			// A miss throws away everything still in flight
			head <= '0;
			tail <= '0;
			count <= '0;
			for (int i = 0; i < rob_depth; i++)
				state[i] <= ROB_EMPTY;
		end
		else begin
			// Results for entries that are not waiting are ignored
			if (done_valid && state[done_tag] == ROB_ISSUED)
				state[done_tag] <= ROB_DONE;
			for (int i = 0; i < COMMIT_LANES; i++)
				if (lane_fire[i])
					state[lane_idx[i]] <= ROB_EMPTY;
			// Free entries at the tail can never be at the head as well
			if (acc0)
				state[disp_tag0] <= ROB_ISSUED;
			if (acc1)
				state[disp_tag1] <= ROB_ISSUED;
			head <= head + n_commit[TAG_W-1:0];
			tail <= tail + n_alloc[TAG_W-1:0];
			count <= count + n_alloc - n_commit;
		end
	end

	// Target and write flag come in at dispatch, the value at completion
	always_ff @(posedge clk) begin
		if (done_valid && state[done_tag] == ROB_ISSUED)
			ent_value[done_tag] <= done_value;
		if (acc0) begin
			ent_wr[disp_tag0] <= alloc0_wr;
			ent_tgt[disp_tag0] <= disp_tgt0;
		end
		if (acc1) begin
			ent_wr[disp_tag1] <= alloc1_wr;
			ent_tgt[disp_tag1] <= disp_tgt1;
		end
	end

	// Occupancy stays within the ring across any mix of dispatch and commit
	assert property (@(posedge clk) disable iff (rst) count <= (TAG_W+1)'(rob_depth));

	// The younger slot never arrives alone
	assert property (@(posedge clk) disable iff (rst) disp_valid1 |-> disp_valid0);

endmodule

//--- source/reg_source_table.sv
// =========================================================================
// Register producer table
// =========================================================================
`timescale 1ns/10ps

module reg_source_table
	import scb_types_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic              alloc0_wr,
	input  reg_idx_t          alloc0_tgt,
	input  rob_tag_t          alloc0_tag,
	input  logic              alloc1_wr,
	input  reg_idx_t          alloc1_tgt,
	input  rob_tag_t          alloc1_tag,
	input  reg_idx_t          commit0_tgt,
	input  reg_idx_t          commit1_tgt,
	input  logic              branchmiss,
	output logic [TAG_BITS:0] src_tag0,
	output logic [TAG_BITS:0] src_tag1
);

	// Newest producer tag per register
	rob_tag_t src_q [NREGS];

	// Set while the stored tag names an entry that has not been flushed
	logic [NREGS-1:0] live_q;

	// A flush leaves no register with an outstanding producer
	always_ff @(posedge clk) begin
		if (rst || branchmiss) begin
			live_q <= '0;
		end
		else begin
			if (alloc0_wr)
				live_q[alloc0_tgt] <= 1'b1;
			if (alloc1_wr)
				live_q[alloc1_tgt] <= 1'b1;
		end
	end

	// Slot 1 is younger so it is written last and wins on equal targets
	always_ff @(posedge clk) begin
		if (alloc0_wr)
			src_q[alloc0_tgt] <= alloc0_tag;
		if (alloc1_wr)
			src_q[alloc1_tgt] <= alloc1_tag;
	end

	// Lookups see the table as it was before this cycle's dispatch
	// The live flag rides along in the top bit
	assign src_tag0 = {live_q[commit0_tgt], src_q[commit0_tgt]};
	assign src_tag1 = {live_q[commit1_tgt], src_q[commit1_tgt]};

endmodule

//--- source/reg_valid_tracker.sv
// =========================================================================
// Register valid bits
// =========================================================================
`timescale 1ns/10ps

module reg_valid_tracker
	import scb_types_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic              alloc0_wr,
	input  reg_idx_t          alloc0_tgt,
	input  logic              alloc1_wr,
	input  reg_idx_t          alloc1_tgt,
	input  logic              commit0_wr,
	input  reg_idx_t          commit0_tgt,
	input  rob_tag_t          commit0_tag,
	input  logic              commit1_wr,
	input  reg_idx_t          commit1_tgt,
	input  rob_tag_t          commit1_tag,
	input  logic [TAG_BITS:0] src_tag0,
	input  logic [TAG_BITS:0] src_tag1,
	input  logic              branchmiss,
	output logic [NREGS-1:0]  valid_bits
);

	logic [NREGS-1:0] valid_next;
	logic             match0;
	logic             match1;

	// A commit only counts when it comes from the newest live producer
	// An older writer retiring must not expose a register still pending
	assign match0 = src_tag0[TAG_BITS] && (src_tag0[TAG_BITS-1:0] == commit0_tag);
	assign match1 = src_tag1[TAG_BITS] && (src_tag1[TAG_BITS-1:0] == commit1_tag);

	// =====================================================================
	// Next state
	// =====================================================================

	// Later assignments override earlier ones, so the order below is the
	// priority with dispatch applied last
	always_comb begin
		valid_next = valid_bits;

		// Nothing stays in flight after a miss
		if (branchmiss)
			valid_next = '1;

		if (commit0_wr && match0)
			valid_next[commit0_tgt] = 1'b1;
		if (commit1_wr && match1)
			valid_next[commit1_tgt] = 1'b1;

		// A new producer hides the register again even if an older one
		// retires into it in the same cycle
		if (alloc0_wr)
			valid_next[alloc0_tgt] = 1'b0;
		if (alloc1_wr)
			valid_next[alloc1_tgt] = 1'b0;

		// Register 0 has no producer
		valid_next[0] = 1'b1;
	end

	// =====================================================================
	// Valid register
	// =====================================================================

	always_ff @(posedge clk) begin
		if (rst)
			valid_bits <= '1;
		else
			valid_bits <= valid_next;
	end

	// The buffer filters register 0 before an allocation reaches this block
	assert property (@(posedge clk) disable iff (rst)
		!(alloc0_wr && alloc0_tgt == '0) && !(alloc1_wr && alloc1_tgt == '0));

endmodule

//--- source/reg_file.sv
// =========================================================================
// Register file, two commit ports
// =========================================================================
`timescale 1ns/10ps

module reg_file
	import scb_types_pkg::*;
#(
	parameter int DATA_WIDTH = 64
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  commit0_wr,
	input  reg_idx_t              commit0_tgt,
	input  logic [DATA_WIDTH-1:0] commit0_value,
	input  logic                  commit1_wr,
	input  reg_idx_t              commit1_tgt,
	input  logic [DATA_WIDTH-1:0] commit1_value,
	input  reg_idx_t              rd_reg,
	output logic [DATA_WIDTH-1:0] rd_value
);

	logic [DATA_WIDTH-1:0] regs [NREGS];

	// Lane 1 holds the younger result, so it is written last
	// Register 0 is never written and keeps its reset zero
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NREGS; i++)
				regs[i] <= '0;
		end
		else begin
			if (commit0_wr && commit0_tgt != '0)
				regs[commit0_tgt] <= commit0_value;
			if (commit1_wr && commit1_tgt != '0)
				regs[commit1_tgt] <= commit1_value;
		end
	end

	// Asynchronous read of registered contents
	assign rd_value = regs[rd_reg];

endmodule

//--- source/scoreboard_top.sv
// =========================================================================
// Register scoreboard top level
// =========================================================================
`timescale 1ns/10ps

module scoreboard_top
	import scb_types_pkg::*;
#(
	parameter int DATA_WIDTH = 64
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  disp_valid0,
	input  logic                  disp_wr0,
	input  reg_idx_t              disp_tgt0,
	input  logic                  disp_valid1,
	input  logic                  disp_wr1,
	input  reg_idx_t              disp_tgt1,
	output logic                  disp_ready,
	output rob_tag_t              disp_tag0,
	output rob_tag_t              disp_tag1,
	input  logic                  done_valid,
	input  rob_tag_t              done_tag,
	input  logic [DATA_WIDTH-1:0] done_value,
	input  logic                  branchmiss,
	input  reg_idx_t              rd_reg,
	output logic [DATA_WIDTH-1:0] rd_value,
	output logic                  rd_valid
);

	// Accepted dispatch slots
	logic     alloc0_wr;
	reg_idx_t alloc0_tgt;
	rob_tag_t alloc0_tag;
	logic     alloc1_wr;
	reg_idx_t alloc1_tgt;
	rob_tag_t alloc1_tag;

	// Retiring entries, one set per lane
	logic                  commit0_wr;
	reg_idx_t              commit0_tgt;
	rob_tag_t              commit0_tag;
	logic [DATA_WIDTH-1:0] commit0_value;
	logic                  commit1_wr;
	reg_idx_t              commit1_tgt;
	rob_tag_t              commit1_tag;
	logic [DATA_WIDTH-1:0] commit1_value;

	// Producer lookups for the commit targets, live flag on top
	logic [TAG_BITS:0] src_tag0;
	logic [TAG_BITS:0] src_tag1;
	logic [NREGS-1:0]  valid_bits;

	reorder_buffer #(
		.rob_depth (ROB_ENTRIES),
		.DATA_WIDTH(DATA_WIDTH)
	) rob_i (
		.clk          (clk),
		.rst          (rst),
		.disp_valid0  (disp_valid0),
		.disp_wr0     (disp_wr0),
		.disp_tgt0    (disp_tgt0),
		.disp_valid1  (disp_valid1),
		.disp_wr1     (disp_wr1),
		.disp_tgt1    (disp_tgt1),
		.disp_ready   (disp_ready),
		.disp_tag0    (disp_tag0),
		.disp_tag1    (disp_tag1),
		.done_valid   (done_valid),
		.done_tag     (done_tag),
		.done_value   (done_value),
		.branchmiss   (branchmiss),
		.alloc0_wr    (alloc0_wr),
		.alloc0_tgt   (alloc0_tgt),
		.alloc0_tag   (alloc0_tag),
		.alloc1_wr    (alloc1_wr),
		.alloc1_tgt   (alloc1_tgt),
		.alloc1_tag   (alloc1_tag),
		.commit0_wr   (commit0_wr),
		.commit0_tgt  (commit0_tgt),
		.commit0_tag  (commit0_tag),
		.commit0_value(commit0_value),
		.commit1_wr   (commit1_wr),
		.commit1_tgt  (commit1_tgt),
		.commit1_tag  (commit1_tag),
		.commit1_value(commit1_value)
	);

	reg_source_table src_i (
		.clk        (clk),
		.rst        (rst),
		.alloc0_wr  (alloc0_wr),
		.alloc0_tgt (alloc0_tgt),
		.alloc0_tag (alloc0_tag),
		.alloc1_wr  (alloc1_wr),
		.alloc1_tgt (alloc1_tgt),
		.alloc1_tag (alloc1_tag),
		.commit0_tgt(commit0_tgt),
		.commit1_tgt(commit1_tgt),
		.branchmiss (branchmiss),
		.src_tag0   (src_tag0),
		.src_tag1   (src_tag1)
	);

	reg_valid_tracker valid_i (
		.clk        (clk),
		.rst        (rst),
		.alloc0_wr  (alloc0_wr),
		.alloc0_tgt (alloc0_tgt),
		.alloc1_wr  (alloc1_wr),
		.alloc1_tgt (alloc1_tgt),
		.commit0_wr (commit0_wr),
		.commit0_tgt(commit0_tgt),
		.commit0_tag(commit0_tag),
		.commit1_wr (commit1_wr),
		.commit1_tgt(commit1_tgt),
		.commit1_tag(commit1_tag),
		.src_tag0   (src_tag0),
		.src_tag1   (src_tag1),
		.branchmiss (branchmiss),
		.valid_bits (valid_bits)
	);

	reg_file #(
		.DATA_WIDTH(DATA_WIDTH)
	) rf_i (
		.clk          (clk),
		.rst          (rst),
		.commit0_wr   (commit0_wr),
		.commit0_tgt  (commit0_tgt),
		.commit0_value(commit0_value),
		.commit1_wr   (commit1_wr),
		.commit1_tgt  (commit1_tgt),
		.commit1_value(commit1_value),
		.rd_reg       (rd_reg),
		.rd_value     (rd_value)
	);

	// Valid flag for the register being read
	assign rd_valid = valid_bits[rd_reg];

endmodule

//--- bench/scoreboard_model.svh
// ==========================================================================
// Scoreboard reference model
// ==========================================================================

// Reorder entries, state 0 is empty, 1 issued and 2 done
int          m_state [8];
logic        m_wr [8];
int          m_tgt [8];
logic [63:0] m_val [8];
int          m_head;
int          m_tail;
int          m_count;

// Per register producer tag, live flag, valid bit and committed value
int          m_src [64];
logic        m_live [64];
logic        m_valid [64];
logic [63:0] m_regs [64];

task automatic reset_model();
	m_head = 0;
	m_tail = 0;
	m_count = 0;
	for (int i = 0; i < 8; i++)
		m_state[i] = 0;
	for (int r = 0; r < 64; r++) begin
		m_src[r] = 0;
		m_live[r] = 1'b0;
		m_valid[r] = 1'b1;
		m_regs[r] = '0;
	end
endtask

// Dispatch needs two free entries and is closed while a miss is signalled
function automatic logic ready_expected(input logic miss);
	return !miss && (8 - m_count >= 2);
endfunction

// One rising edge of the scoreboard, given the inputs held across it
task automatic advance_model(input logic v0, input logic wr0, input int t0,
		input logic v1, input logic wr1, input int t1,
		input logic dv, input int dtag, input logic [63:0] dval, input logic miss);
	int   c_idx [2];
	logic c_fire [2];
	logic c_hit [2];
	logic rdy;
	logic a0;
	logic a1;
	rdy = ready_expected(miss);
	c_idx[0] = m_head;
	c_idx[1] = (m_head + 1) % 8;
	// Lane 1 only retires behind lane 0
	c_fire[0] = (m_state[c_idx[0]] == 2);
	c_fire[1] = c_fire[0] && (m_state[c_idx[1]] == 2);
	// A commit revalidates only when it is the newest live producer
	for (int l = 0; l < 2; l++)
		c_hit[l] = c_fire[l] && m_wr[c_idx[l]] && m_live[m_tgt[c_idx[l]]]
			&& (m_src[m_tgt[c_idx[l]]] == c_idx[l]);
	a0 = v0 && rdy && wr0 && (t0 != 0);
	a1 = v1 && rdy && wr1 && (t1 != 0);

	// Valid bits, flush first, then commits, dispatch last so it wins
	if (miss)
		for (int r = 0; r < 64; r++)
			m_valid[r] = 1'b1;
	for (int l = 0; l < 2; l++)
		if (c_hit[l])
			m_valid[m_tgt[c_idx[l]]] = 1'b1;
	if (a0)
		m_valid[t0] = 1'b0;
	if (a1)
		m_valid[t1] = 1'b0;
	m_valid[0] = 1'b1;

	// Committed values, the younger lane is written last
	for (int l = 0; l < 2; l++)
		if (c_fire[l] && m_wr[c_idx[l]] && (m_tgt[c_idx[l]] != 0))
			m_regs[m_tgt[c_idx[l]]] = m_val[c_idx[l]];

	// Producer table, slot 1 overrides slot 0 on a shared target
	if (miss) begin
		for (int r = 0; r < 64; r++)
			m_live[r] = 1'b0;
	end
	else begin
		if (a0) begin
			m_src[t0] = m_tail;
			m_live[t0] = 1'b1;
		end
		if (a1) begin
			m_src[t1] = (m_tail + 1) % 8;
			m_live[t1] = 1'b1;
		end
	end

	// Reorder ring
	if (miss) begin
		reset_model_ring();
	end
	else begin
		if (dv && m_state[dtag] == 1) begin
			m_state[dtag] = 2;
			m_val[dtag] = dval;
		end
		for (int l = 0; l < 2; l++)
			if (c_fire[l]) begin
				m_state[c_idx[l]] = 0;
				m_head = (m_head + 1) % 8;
				m_count--;
			end
		if (v0 && rdy) begin
			m_state[m_tail] = 1;
			m_wr[m_tail] = a0;
			m_tgt[m_tail] = t0;
			m_tail = (m_tail + 1) % 8;
			m_count++;
		end
		if (v1 && rdy) begin
			m_state[m_tail] = 1;
			m_wr[m_tail] = a1;
			m_tgt[m_tail] = t1;
			m_tail = (m_tail + 1) % 8;
			m_count++;
		end
	end
endtask

// A miss drops every entry still in flight
task automatic reset_model_ring();
	m_head = 0;
	m_tail = 0;
	m_count = 0;
	for (int i = 0; i < 8; i++)
		m_state[i] = 0;
endtask

//--- bench/scoreboard_tb.sv
// ==========================================================================
// Scoreboard testbench
// ==========================================================================
`timescale 1ns/10ps

module scoreboard_tb
	import scb_types_pkg::*;
();

	// ======================================================================
	// Test lengths in clock cycles
	// ======================================================================
	localparam int RESET_CYCLES = 16;
	localparam int LEN_RESET = 64;
	localparam int LEN_ZERO = 200;
	localparam int LEN_ORDER = 600;
	localparam int LEN_SAME = 400;
	localparam int LEN_MISS = 400;
	localparam int LEN_FULL = 40;
	localparam int LEN_DRAIN = 200;
	localparam int TOTAL = LEN_RESET + LEN_ZERO + LEN_ORDER + LEN_SAME + LEN_MISS
		+ LEN_FULL + LEN_DRAIN;
	localparam int MARGIN = 100;

	logic     clk;
	logic     rst;
	logic     disp_valid0;
	logic     disp_wr0;
	reg_idx_t disp_tgt0;
	logic     disp_valid1;
	logic     disp_wr1;
	reg_idx_t disp_tgt1;
	logic     disp_ready;
	rob_tag_t disp_tag0;
	rob_tag_t disp_tag1;
	logic     done_valid;
	rob_tag_t done_tag;
	word_t    done_value;
	logic     branchmiss;
	reg_idx_t rd_reg;
	word_t    rd_value;
	logic     rd_valid;

	integer seed;
	int     errors;
	int     checks;
	int     cyc;
	logic   held;
	string  test_name;

	`include "scoreboard_model.svh"

	initial clk = 1'b0;
	always #50 clk = ~clk;

	scoreboard_top #(
		.DATA_WIDTH(64)
	) dut_i (
		.clk        (clk),
		.rst        (rst),
		.disp_valid0(disp_valid0),
		.disp_wr0   (disp_wr0),
		.disp_tgt0  (disp_tgt0),
		.disp_valid1(disp_valid1),
		.disp_wr1   (disp_wr1),
		.disp_tgt1  (disp_tgt1),
		.disp_ready (disp_ready),
		.disp_tag0  (disp_tag0),
		.disp_tag1  (disp_tag1),
		.done_valid (done_valid),
		.done_tag   (done_tag),
		.done_value (done_value),
		.branchmiss (branchmiss),
		.rd_reg     (rd_reg),
		.rd_value   (rd_value),
		.rd_valid   (rd_valid)
	);

	// True with the given percentage
	function automatic logic chance(input int pct);
		return (($random(seed) & 32'h7fffffff) % 100) < pct;
	endfunction

	function automatic int pick(input int mask);
		return $random(seed) & mask;
	endfunction

	task automatic compare(input string what, input logic [63:0] exp, input logic [63:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("** Error %s: %s expected %0h, actual %0h", test_name, what, exp, act);
		end
	endtask

	// Outputs are settled one step after the falling edge drive
	task automatic check_outputs();
		logic rdy;
		rdy = ready_expected(branchmiss);
		compare("disp_ready", rdy, disp_ready);
		compare("rd_value", m_regs[rd_reg], rd_value);
		compare("rd_valid", m_valid[rd_reg], rd_valid);
		if (disp_valid0 && rdy) begin
			compare("disp_tag0", m_tail, disp_tag0);
			compare("disp_tag1", (m_tail + 1) % 8, disp_tag1);
		end
	endtask

	// ======================================================================
	// Random phase, percentages per cycle and a mask on register numbers
	// ======================================================================
	task automatic run_phase(input string name, input int len, input int p_disp,
			input int p_done, input int p_miss, input int mask);
		test_name = name;
		for (int n = 0; n < len; n++) begin
			@(negedge clk);
			// A dispatch that was not taken stays on the inputs
			if (!held) begin
				disp_valid0 = chance(p_disp);
				disp_valid1 = disp_valid0 && chance(50);
				disp_wr0 = chance(85);
				disp_wr1 = chance(85);
				disp_tgt0 = reg_idx_t'(pick(mask));
				disp_tgt1 = reg_idx_t'(pick(mask));
			end
			done_valid = chance(p_done);
			done_tag = rob_tag_t'(pick(7));
			done_value = {$random(seed), $random(seed)};
			// Never two miss cycles in a row
			branchmiss = !branchmiss && chance(p_miss);
			rd_reg = reg_idx_t'(cyc & mask);
			#1;
			check_outputs();
			held = disp_valid0 && !ready_expected(branchmiss);
			@(posedge clk);
			advance_model(disp_valid0, disp_wr0, disp_tgt0, disp_valid1, disp_wr1,
				disp_tgt1, done_valid, done_tag, done_value, branchmiss);
			cyc++;
		end
	endtask

	initial begin
		seed = 73317;
		errors = 0;
		checks = 0;
		cyc = 0;
		held = 1'b0;
		rst = 1'b1;
		disp_valid0 = 1'b0;
		disp_wr0 = 1'b0;
		disp_tgt0 = '0;
		disp_valid1 = 1'b0;
		disp_wr1 = 1'b0;
		disp_tgt1 = '0;
		done_valid = 1'b0;
		done_tag = '0;
		done_value = '0;
		branchmiss = 1'b0;
		rd_reg = '0;
		reset_model();
		test_name = "reset";
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		run_phase("reset_state", LEN_RESET, 0, 0, 0, 63);
		// Targets 0 and 1 only, so register 0 is written and committed often
		run_phase("reg_zero", LEN_ZERO, 60, 70, 0, 1);
		run_phase("inorder_commit", LEN_ORDER, 60, 70, 0, 63);
		// Few targets force shared registers within and across cycles
		run_phase("same_target", LEN_SAME, 70, 60, 0, 3);
		run_phase("branch_miss", LEN_MISS, 60, 60, 5, 7);
		// No completions, the buffer fills and dispatch is held
		run_phase("backpressure", LEN_FULL, 100, 0, 0, 63);
		run_phase("drain", LEN_DRAIN, 20, 90, 0, 63);

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	// Watchdog sized from the test lengths
	initial begin
		#((RESET_CYCLES + TOTAL + MARGIN) * 100);
		$display("Watchdog expired, the test sequence did not finish in time");
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

//--- scoreboard.f
+incdir+bench
source/scb_types_pkg.sv
source/scb_ctrl_pkg.sv
source/reorder_buffer.sv
source/reg_source_table.sv
source/reg_valid_tracker.sv
source/reg_file.sv
source/scoreboard_top.sv
bench/scoreboard_tb.sv

//--- Bender.yml
package:
  name: scoreboard

sources:
  # Packages first, then the blocks, then the top level
  - files:
      - source/scb_types_pkg.sv
      - source/scb_ctrl_pkg.sv
      - source/reorder_buffer.sv
      - source/reg_source_table.sv
      - source/reg_valid_tracker.sv
      - source/reg_file.sv
      - source/scoreboard_top.sv

  # Testbench with its model header
  - target: test
    include_dirs:
      - bench
    files:
      - bench/scoreboard_tb.sv
